// File: build.f
+incdir+source
source/rgmii_tx_pkg.sv
source/frame_stager.sv
source/fcs_generator.sv
source/rgmii_byte_shipper.sv
source/rgmii_tx.sv
dv/rgmii_tx_chk.sv
dv/tb_rgmii_tx.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rgmii_tx -f build.f -o sim_tb_rgmii_tx
./obj_dir/sim_tb_rgmii_tx +verilator+error+limit+1000 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
grep -q "NO ERRORS" sim.log

// File: dv/tb_rgmii_tx.sv
`timescale 1ns/1ps
`include "rgmii_tx_defs.svh"

module tb_rgmii_tx;

localparam int FRAMES      = 60;
localparam int MAX_PAYLOAD = 40;
localparam int MAX_IDLE    = 3;
localparam int PERIOD      = 40;
localparam int HEADER      = `RGMII_PREAMBLE_BYTES + 1;
// Input side and wire side of one frame never overlap
localparam int FRAME_CYCLES = (MAX_IDLE + 1) * MAX_PAYLOAD + HEADER + MAX_PAYLOAD + 4
                              + `RGMII_GAP_CYCLES + 8;
localparam int TIMEOUT_NS  = ((FRAMES + 1) * FRAME_CYCLES + 200) * PERIOD;

logic                       clock;
logic                       reset_n;
rgmii_tx_pkg::tagged_byte_t data;
logic                       data_enable;
logic                       data_ready;
rgmii_tx_pkg::rgmii_tx_t    rgmii;

integer     seed;
integer     byte_errors = 0;
integer     fcs_errors = 0;
integer     gap_errors = 0;
integer     length_errors = 0;
integer     other_errors = 0;
integer     frames_seen = 0;
logic [7:0] expected_q[$];
integer     length_q[$];

rgmii_tx i_rgmii_tx (
    .clock          (clock),
    .reset_n        (reset_n),
    .data           (data),
    .data_enable    (data_enable),
    .data_ready     (data_ready),
    .rgmii          (rgmii)
);

bind rgmii_tx rgmii_tx_chk chk (
    .clock          (clock),
    .reset_n        (reset_n),
    .data_enable    (data_enable),
    .data_ready     (data_ready),
    .rgmii          (rgmii)
);

initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
end

//////////////////////////////////////////////////
// Reference CRC and compare tasks

// Ethernet CRC-32, one data bit at a time
function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] value);
    logic [31:0] c;
    logic        feedback;
    c = crc;
    for (int b = 0; b < 8; b++) begin
        feedback = c[0] ^ value[b];
        c = {1'b0, c[31:1]};
        if (feedback) begin
            c = c ^ `RGMII_CRC_POLY;
        end
    end
    return c;
endfunction

function automatic integer error_total();
    return byte_errors + fcs_errors + gap_errors + length_errors + other_errors
           + i_rgmii_tx.chk.failures;
endfunction

task automatic check_byte(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %02h, actual %02h", name, expected, actual);
        byte_errors++;
    end
endtask

task automatic check_fcs(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
        fcs_errors++;
    end
endtask

task automatic check_gap(input string name, input integer expected, input integer actual);
    if (actual < expected) begin
        $display("FAILED %s: expected at least %0d, actual %0d", name, expected, actual);
        gap_errors++;
    end
endtask

task automatic check_length(input string name, input integer expected, input integer actual);
    if (actual != expected) begin
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        length_errors++;
    end
endtask

task automatic report_counts();
    $display("Error counts: byte %0d, fcs %0d, gap %0d, length %0d, other %0d, assertion %0d",
             byte_errors, fcs_errors, gap_errors, length_errors, other_errors,
             i_rgmii_tx.chk.failures);
endtask

task automatic compare_frame(input logic [7:0] rx[$]);
    integer      len;
    logic [31:0] crc;
    logic [7:0]  want;
    if (length_q.size() == 0) begin
        $display("Frame %0d appeared on the wire but no frame was sent", frames_seen);
        other_errors++;
        return;
    end
    len = length_q.pop_front();
    check_length($sformatf("frame %0d length", frames_seen), HEADER + len + 4, rx.size());
    crc = `RGMII_CRC_INIT;
    for (int i = 0; i < len; i++) begin
        want = expected_q.pop_front();
        crc  = crc_step(crc, want);
        if (rx.size() == HEADER + len + 4) begin
            check_byte($sformatf("frame %0d payload %0d", frames_seen, i), want, rx[HEADER + i]);
        end
    end
    if (rx.size() == HEADER + len + 4) begin
        for (int i = 0; i < `RGMII_PREAMBLE_BYTES; i++) begin
            check_byte($sformatf("frame %0d preamble", frames_seen), 8'h55, rx[i]);
        end
        check_byte($sformatf("frame %0d delimiter", frames_seen), 8'hD5, rx[HEADER - 1]);
        // FCS goes out low byte first
        check_fcs($sformatf("frame %0d fcs", frames_seen), ~crc,
                  {rx[HEADER + len + 3], rx[HEADER + len + 2],
                   rx[HEADER + len + 1], rx[HEADER + len]});
    end
    frames_seen++;
endtask

//////////////////////////////////////////////////
// Stimulus

task automatic hold_off(input integer cycles);
    data_enable = 1'b0;
    repeat (cycles) begin
        @(posedge clock);
        #2;
    end
endtask

task automatic send_byte(input logic start, input logic [7:0] value);
    logic accepted;
    data.start  = start;
    data.value  = value;
    data_enable = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
        @(negedge clock);
        accepted = data_ready;
        @(posedge clock);
        #2;
    end
    data_enable = 1'b0;
endtask

initial begin : stimulus
    integer     len;
    logic [7:0] value;
    seed        = 83751;
    data        = '0;
    data_enable = 1'b0;
    reset_n     = 1'b0;
    repeat (4) @(posedge clock);
    #2;
    reset_n = 1'b1;
    hold_off(2);
    if (rgmii.tx_ctl !== 1'b0 || data_ready !== 1'b0) begin
        $display("tx_ctl or data_ready is high after reset with no input");
        other_errors++;
    end

    // No frame open yet, these are dropped
    repeat (3) send_byte(1'b0, 8'($random(seed)));

    for (int f = 0; f < FRAMES; f++) begin
        len = 1 + ({$random(seed)} % MAX_PAYLOAD);
        length_q.push_back(len);
        for (int i = 0; i < len; i++) begin
            value = 8'($random(seed));
            hold_off({$random(seed)} % (MAX_IDLE + 1));
            send_byte(i == 0, value);
            if (i == 0 && frames_seen != f) begin
                $display("Start byte of frame %0d accepted before frame %0d left the wire",
                         f, f - 1);
                other_errors++;
            end
            expected_q.push_back(value);
        end
    end
    // Closes the last frame
    send_byte(1'b1, 8'($random(seed)));
    wait (frames_seen == FRAMES);
    hold_off(4);
    if (expected_q.size() != 0 || length_q.size() != 0) begin
        $display("Sent frames are left over that never appeared on the wire");
        other_errors++;
    end

    report_counts();
    if (error_total() == 0) begin
        $display("NO ERRORS");
    end
    else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

//////////////////////////////////////////////////
// Wire monitor

initial begin : wire_monitor
    logic [7:0] frame[$];
    logic [3:0] low_nibble;
    integer     idle_cycles;
    idle_cycles = -1;
    forever begin
        @(posedge clock);
        #19;
        if (rgmii.tx_ctl) begin
            low_nibble = rgmii.txd;
            #20;
            if (frame.size() == 0 && idle_cycles >= 0) begin
                check_gap($sformatf("gap before frame %0d", frames_seen),
                          `RGMII_GAP_CYCLES, idle_cycles);
            end
            frame.push_back({rgmii.txd, low_nibble});
        end
        else begin
            if (frame.size() != 0) begin
                compare_frame(frame);
                frame.delete();
                idle_cycles = 0;
            end
            if (idle_cycles >= 0) begin
                idle_cycles++;
            end
        end
    end
end

initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d frames left the wire in time", frames_seen, FRAMES);
    report_counts();
    $display("ERRORS FOUND");
    $finish;
end

endmodule

// File: dv/rgmii_tx_chk.sv
`timescale 1ns/1ps

module rgmii_tx_chk (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        data_enable,
    input  logic                        data_ready,
    input  rgmii_tx_pkg::rgmii_tx_t     rgmii
);

localparam logic [7:0] MIN_BURST = 8'd12;

integer     failures = 0;
logic [7:0] high_run;

// Length of the current tx_ctl burst
always_ff @(posedge clock) begin
    if (!reset_n || !rgmii.tx_ctl) begin
        high_run <= '0;
    end
    else begin
        high_run <= high_run + 8'd1;
    end
end

ready_needs_enable: assert property (@(posedge clock) disable iff (!reset_n)
    data_ready |-> data_enable)
    else begin
        $error("data_ready is high while data_enable is low");
        failures = failures + 1;
    end

quiet_in_reset: assert property (@(posedge clock)
    (!reset_n && !$past(reset_n)) |-> !rgmii.tx_ctl)
    else begin
        $error("tx_ctl is high during reset");
        failures = failures + 1;
    end

burst_length: assert property (@(posedge clock) disable iff (!reset_n)
    (!rgmii.tx_ctl && high_run != 8'd0) |-> high_run >= MIN_BURST)
    else begin
        $error("tx_ctl burst ended after fewer than 12 cycles");
        failures = failures + 1;
    end

endmodule

// File: source/rgmii_tx.sv
`timescale 1ns/1ps

module rgmii_tx (
    input  logic                        clock,
    input  logic                        reset_n,
    input  rgmii_tx_pkg::tagged_byte_t  data,
    input  logic                        data_enable,
    output logic                        data_ready,
    output rgmii_tx_pkg::rgmii_tx_t     rgmii
);

rgmii_tx_pkg::stage_write_t stage_write;
rgmii_tx_pkg::stage_read_t  stage_head;
logic                       frame_ready;
logic                       stage_pop;
logic                       frame_done;
logic   [31:0]              fcs;

frame_stager stager (
    .clock          (clock),
    .reset_n        (reset_n),
    .data           (data),
    .data_enable    (data_enable),
    .data_ready     (data_ready),
    .stage_write    (stage_write),
    .stage_head     (stage_head),
    .frame_ready    (frame_ready),
    .stage_pop      (stage_pop),
    .frame_done     (frame_done)
);

fcs_generator fcs_gen (
    .clock          (clock),
    .reset_n        (reset_n),
    .stage_write    (stage_write),
    .fcs            (fcs)
);

rgmii_byte_shipper shipper (
    .clock          (clock),
    .reset_n        (reset_n),
    .frame_ready    (frame_ready),
    .stage_head     (stage_head),
    .fcs            (fcs),
    .stage_pop      (stage_pop),
    .frame_done     (frame_done),
    .rgmii          (rgmii)
);

endmodule

// File: source/rgmii_byte_shipper.sv
`timescale 1ns/1ps
`include "rgmii_tx_defs.svh"

module rgmii_byte_shipper (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        frame_ready,
    input  rgmii_tx_pkg::stage_read_t   stage_head,
    input  logic [31:0]                 fcs,
    output logic                        stage_pop,
    output logic                        frame_done,
    output rgmii_tx_pkg::rgmii_tx_t     rgmii
);

localparam logic [7:0] PREAMBLE_LOAD = 8'(`RGMII_PREAMBLE_BYTES - 2);
localparam logic [7:0] FCS_LOAD      = 8'd2;
localparam logic [7:0] GAP_LOAD      = 8'(`RGMII_GAP_CYCLES - 1);

typedef enum logic [2:0] {
    S_IDLE,
    S_PREAMBLE,
    S_DELIMITER,
    S_PAYLOAD,
    S_FCS,
    S_GAP
} state_t;

state_t         state;
state_t         _state;
logic   [7:0]   counter;
logic   [7:0]   _counter;
logic   [7:0]   tx_byte;
logic   [7:0]   _tx_byte;
logic           tx_valid;
logic           _tx_valid;
logic   [7:0]   wire_byte;
logic           wire_valid;

//////////////////////////////////////////////////
// Frame sequencer

always_comb begin
    _state     = state;
    _counter   = counter;
    _tx_byte   = tx_byte;
    _tx_valid  = 1'b0;
    stage_pop  = 1'b0;
    frame_done = 1'b0;

    case (state)
        S_IDLE: begin
            // First preamble byte goes out right away
            if (frame_ready) begin
                _tx_byte  = 8'h55;
                _tx_valid = 1'b1;
                _counter  = PREAMBLE_LOAD;
                _state    = S_PREAMBLE;
            end
        end
        S_PREAMBLE: begin
            _tx_byte  = 8'h55;
            _tx_valid = 1'b1;
            _counter  = counter - 1'b1;
            if (counter == '0) begin
                _state = S_DELIMITER;
            end
        end
        S_DELIMITER: begin
            _tx_byte  = 8'hD5;
            _tx_valid = 1'b1;
            _state    = S_PAYLOAD;
        end
        S_PAYLOAD: begin
            _tx_valid = 1'b1;
            if (stage_head.valid) begin
                _tx_byte  = stage_head.value;
                stage_pop = 1'b1;
            end
            else begin
                // Staging drained, low FCS byte fills this slot
                _tx_byte = fcs[7:0];
                _counter = FCS_LOAD;
                _state   = S_FCS;
            end
        end
        S_FCS: begin
            _tx_byte  = fcs[8 * (3 - counter[1:0]) +: 8];
            _tx_valid = 1'b1;
            _counter  = counter - 1'b1;
            if (counter == '0) begin
                _counter = GAP_LOAD;
                _state   = S_GAP;
            end
        end
        S_GAP: begin
            _counter = counter - 1'b1;
            if (counter == '0) begin
                frame_done = 1'b1;
                _state     = S_IDLE;
            end
        end
        default: begin
            _state = S_IDLE;
        end
    endcase
end

always_ff @(posedge clock) begin
    if (!reset_n) begin
        state    <= S_IDLE;
        counter  <= '0;
        tx_valid <= 1'b0;
    end
    else begin
        state    <= _state;
        counter  <= _counter;
        tx_valid <= _tx_valid;
    end
end

always_ff @(posedge clock) begin
    tx_byte <= _tx_byte;
end

//////////////////////////////////////////////////
// DDR output stage

always_ff @(posedge clock) begin
    if (!reset_n) begin
        wire_valid <= 1'b0;
    end
    else begin
        wire_valid <= tx_valid;
    end
end

always_ff @(posedge clock) begin
    wire_byte <= tx_byte;
end

// Low nibble in the high phase, high nibble in the low phase
always_comb begin
    rgmii.tx_ctl = wire_valid;
    rgmii.txd    = clock ? wire_byte[3:0] : wire_byte[7:4];
end

endmodule

// File: source/fcs_generator.sv
`timescale 1ns/1ps
`include "rgmii_tx_defs.svh"

module fcs_generator (
    input  logic                        clock,
    input  logic                        reset_n,
    input  rgmii_tx_pkg::stage_write_t  stage_write,
    output logic [31:0]                 fcs
);

logic   [31:0]  crc;
logic   [31:0]  seed;

// One byte, LSB first, eight shifts unrolled in a single cycle
function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] value);
    logic [31:0] next;
    next = crc_in ^ {24'd0, value};
    for (int i = 0; i < 8; i++) begin
        if (next[0]) begin
            next = (next >> 1) ^ `RGMII_CRC_POLY;
        end
        else begin
            next = next >> 1;
        end
    end
    return next;
endfunction

// Restart on the opening byte of every frame
assign seed = stage_write.first ? `RGMII_CRC_INIT : crc;

always_ff @(posedge clock) begin
    if (!reset_n) begin
        crc <= `RGMII_CRC_INIT;
    end
    else if (stage_write.valid) begin
        crc <= crc_byte(seed, stage_write.value);
    end
end

// Held while the frame sits closed in staging
assign fcs = ~crc;

endmodule

// File: source/frame_stager.sv
`timescale 1ns/1ps
`include "rgmii_tx_defs.svh"

module frame_stager (
    input  logic                        clock,
    input  logic                        reset_n,
    input  rgmii_tx_pkg::tagged_byte_t  data,
    input  logic                        data_enable,
    output logic                        data_ready,
    output rgmii_tx_pkg::stage_write_t  stage_write,
    output rgmii_tx_pkg::stage_read_t   stage_head,
    output logic                        frame_ready,
    input  logic                        stage_pop,
    input  logic                        frame_done
);

localparam int ADDR_WIDTH = $clog2(`RGMII_STAGE_DEPTH);
// One slot kept free for the byte still sitting in stage_write
localparam logic [ADDR_WIDTH:0] FULL_LEVEL = (ADDR_WIDTH + 1)'(`RGMII_STAGE_DEPTH - 1);

typedef enum logic [1:0] {
    S_HUNT,
    S_COLLECT,
    S_CLOSED
} state_t;

state_t                         state;
state_t                         _state;
rgmii_tx_pkg::stage_write_t     _stage_write;
logic   [7:0]                   memory [`RGMII_STAGE_DEPTH];
logic   [ADDR_WIDTH:0]          write_pointer;
logic   [ADDR_WIDTH:0]          read_pointer;
logic   [ADDR_WIDTH:0]          fill;
logic                           full;

assign fill = write_pointer - read_pointer;
assign full = fill >= FULL_LEVEL;

//////////////////////////////////////////////////
// Frame boundary capture

always_comb begin
    _state     = state;
    data_ready = 1'b0;

    case (state)
        S_HUNT: begin
            // Non-start bytes are taken and dropped
            data_ready = data_enable;
            if (data_enable && data.start) begin
                _state = S_COLLECT;
            end
        end
        S_COLLECT: begin
            if (data_enable) begin
                if (data.start) begin
                    _state = S_CLOSED;
                end
                else begin
                    data_ready = !full;
                end
            end
        end
        S_CLOSED: begin
            // Next start byte waits at the source
            if (frame_done) begin
                _state = S_HUNT;
            end
        end
        default: begin
            _state = S_HUNT;
        end
    endcase
end

always_comb begin
    _stage_write.valid = data_ready && (state == S_COLLECT || data.start);
    _stage_write.first = data_ready && (state == S_HUNT) && data.start;
    _stage_write.value = data.value;
end

always_ff @(posedge clock) begin
    if (!reset_n) begin
        state       <= S_HUNT;
        stage_write <= '0;
    end
    else begin
        state       <= _state;
        stage_write <= _stage_write;
    end
end

assign frame_ready = (state == S_CLOSED);

//////////////////////////////////////////////////
// Staging memory

always_ff @(posedge clock) begin
    if (!reset_n || frame_done) begin
        write_pointer <= '0;
        read_pointer  <= '0;
    end
    else begin
        if (stage_write.valid) begin
            write_pointer <= write_pointer + 1'b1;
        end
        if (stage_pop) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end
end

always_ff @(posedge clock) begin
    if (stage_write.valid) begin
        memory[write_pointer[ADDR_WIDTH-1:0]] <= stage_write.value;
    end
end

// First word falls through
assign stage_head.valid = (fill != '0);
assign stage_head.value = memory[read_pointer[ADDR_WIDTH-1:0]];

endmodule

// File: source/rgmii_tx_pkg.sv
package rgmii_tx_pkg;

    // Byte from the source, start marks the first byte of a frame
    typedef struct packed {
        logic       start;
        logic [7:0] value;
    } tagged_byte_t;

    // Accepted byte on its way into staging and the FCS
    typedef struct packed {
        logic       valid;
        logic       first;
        logic [7:0] value;
    } stage_write_t;

    // Fall-through head of the staging memory
    typedef struct packed {
        logic       valid;
        logic [7:0] value;
    } stage_read_t;

    // RGMII transmit pins
    typedef struct packed {
        logic       tx_ctl;
        logic [3:0] txd;
    } rgmii_tx_t;

endpackage

// File: source/rgmii_tx_defs.svh
`ifndef RGMII_TX_DEFS_SVH
`define RGMII_TX_DEFS_SVH

// Staging memory size in payload bytes
`define RGMII_STAGE_DEPTH       2048

// Wire framing
`define RGMII_PREAMBLE_BYTES    7
`define RGMII_GAP_CYCLES        12

// Reflected CRC-32 as used by the Ethernet FCS
`define RGMII_CRC_POLY          32'hEDB88320
`define RGMII_CRC_INIT          32'hFFFFFFFF

`endif
